// File: mem_hierarchy.f
design/cache_types_pkg.sv
design/mem_bus_pkg.sv
design/direct_mapped_cache.sv
design/cache_arbiter.sv
design/cacheline_adaptor.sv
design/mem_hierarchy.sv
tests/burst_mem_model.sv
tests/tb_mem_hierarchy.sv

// File: Bender.yml
package:
  name: mem_hierarchy

sources:
  - files:
      - design/cache_types_pkg.sv
      - design/mem_bus_pkg.sv
      - design/direct_mapped_cache.sv
      - design/cache_arbiter.sv
      - design/cacheline_adaptor.sv
      - design/mem_hierarchy.sv
  - target: test
    files:
      - tests/burst_mem_model.sv
      - tests/tb_mem_hierarchy.sv

// File: tests/tb_mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hierarchy;
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int    CLK_HALF     = 20;
    localparam int    RESET_CYCLES = 10;
    localparam int    RESP_TIMEOUT = 200;
    localparam int    NUM_TESTS    = 6;
    localparam int    TEST_CYCLES  = 2000;
    localparam int    MIX_OPS      = 200;
    localparam word_t DATA_BASE    = 32'h0000_1000;
    localparam word_t INSTR_BASE   = 32'h0000_8000;  // kept apart from data, no coherence

    logic       clk = 1'b0;
    logic       rst_i;
    word_req_t  imem_req;
    word_rsp_t  imem_rsp;
    word_req_t  dmem_req;
    word_rsp_t  dmem_rsp;
    burst_req_t bmem_req;
    burst_t     bmem_rdata;
    logic       bmem_resp;

    word_t  ref_mem [word_t];
    word_t  wb_words [word_t];  // last words seen on bmem writes
    int     wr_beats = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     tests_run = 0;
    integer seed = 63;

    mem_hierarchy u_mem_hierarchy (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_req_i   (imem_req),
        .imem_rsp_o   (imem_rsp),
        .dmem_req_i   (dmem_req),
        .dmem_rsp_o   (dmem_rsp),
        .bmem_req_o   (bmem_req),
        .bmem_rdata_i (bmem_rdata),
        .bmem_resp_i  (bmem_resp)
    );

    burst_mem_model u_burst_mem (
        .clk          (clk),
        .rst_i        (rst_i),
        .bmem_req_i   (bmem_req),
        .bmem_rdata_o (bmem_rdata),
        .bmem_resp_o  (bmem_resp)
    );

    always #CLK_HALF clk = ~clk;

    always @(negedge clk) begin
        if (bmem_req.write && bmem_resp) begin
            wb_words[bmem_req.addr + 8 * (wr_beats % BURST_BEATS)]     = bmem_req.wdata[31:0];
            wb_words[bmem_req.addr + 8 * (wr_beats % BURST_BEATS) + 4] = bmem_req.wdata[63:32];
            wr_beats++;
        end
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 2 * CLK_HALF);
        $display("watchdog expired before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic word_t ref_read(word_t addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : ~addr;
    endfunction

    function automatic void ref_write(word_t addr, logic [3:0] mask, word_t data);
        word_t w;
        w = ref_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) w[b*8 +: 8] = data[b*8 +: 8];
        end
        ref_mem[addr] = w;
    endfunction

    task automatic check_word(input string test, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", test, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        assert (act == exp) else begin
            $display("ERROR %s: expected %0d, actual %0d", test, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // called and left at 2 ns after a rising edge
    task automatic access_port(input string test, input bit is_imem, input bit wr,
                               input word_t addr, input logic [3:0] mask, input word_t wdata,
                               output word_t rdata, output int cycles);
        word_req_t req;
        bit        done;
        req = '{addr: addr, read: ~wr, write: wr, wmask: wr ? mask : 4'h0, wdata: wdata};
        if (is_imem) imem_req = req;
        else dmem_req = req;
        cycles = 0;
        done   = 1'b0;
        rdata  = '0;
        while (!done && cycles < RESP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            done  = is_imem ? imem_rsp.resp : dmem_rsp.resp;
            rdata = is_imem ? imem_rsp.rdata : dmem_rsp.rdata;
        end
        assert (done) else begin
            $display("%s: no resp within %0d cycles for access to %h", test, RESP_TIMEOUT, addr);
            errors++;
            test_errors++;
        end
        @(posedge clk);
        #2;
        if (is_imem) imem_req = '0;
        else dmem_req = '0;
    endtask

    task automatic read_check(input string test, input bit is_imem, input word_t addr,
                              output int cycles);
        word_t rdata;
        access_port(test, is_imem, 1'b0, addr, 4'h0, '0, rdata, cycles);
        check_word(test, ref_read(addr), rdata);
    endtask

    task automatic write_check(input string test, input word_t addr, input logic [3:0] mask,
                               input word_t data);
        word_t rdata;
        int    cycles;
        access_port(test, 1'b0, 1'b1, addr, mask, data, rdata, cycles);
        ref_write(addr, mask, data);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) $display("%-16s passed", name);
        else $display("%-16s failed with %0d errors", name, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    task automatic read_miss_then_hit();
        int cycles;
        read_check("read_miss_hit", 1'b0, 32'h0000_1004, cycles);
        read_check("read_miss_hit", 1'b0, 32'h0000_1010, cycles);  // same line
        check_count("read_miss_hit", 2, cycles);
        finish_test("read_miss_hit");
    endtask

    task automatic partial_write_merge();
        int cycles;
        int beats_before;
        beats_before = wr_beats;
        write_check("partial_write", 32'h0000_1024, 4'b0101, 32'ha5a5_5a5a);
        read_check("partial_write", 1'b0, 32'h0000_1024, cycles);
        write_check("partial_write", 32'h0000_1024, 4'b1000, 32'h3c00_0000);
        read_check("partial_write", 1'b0, 32'h0000_1024, cycles);
        check_count("partial_write", beats_before, wr_beats);  // line stays resident
        finish_test("partial_write");
    endtask

    task automatic dirty_eviction();
        word_t victim;
        word_t line_base;
        word_t seen;
        int    cycles;
        int    beats_before;
        victim    = 32'h0000_1048;
        line_base = {victim[31:5], 5'b0};
        write_check("dirty_evict", victim, 4'hf, 32'h1234_5678);
        beats_before = wr_beats;
        wb_words.delete();
        read_check("dirty_evict", 1'b0, victim + 32'd256, cycles);  // same set, new tag
        check_count("dirty_evict", BURST_BEATS, wr_beats - beats_before);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            seen = wb_words.exists(line_base + 4 * w) ? wb_words[line_base + 4 * w] : 'x;
            check_word("dirty_evict", ref_read(line_base + 4 * w), seen);
        end
        read_check("dirty_evict", 1'b0, victim, cycles);
        finish_test("dirty_evict");
    endtask

    task automatic imem_set_sweep();
        int cycles;
        int beats_before;
        beats_before = wr_beats;
        for (int s = 0; s < NUM_SETS; s++) begin
            read_check("imem_sets", 1'b1, 32'h0000_2000 + 36 * s, cycles);
            read_check("imem_sets", 1'b1, 32'h0000_201c + 32 * s, cycles);
            read_check("imem_sets", 1'b1, 32'h0000_2100 + 36 * s, cycles);  // evicts the set
        end
        check_count("imem_sets", beats_before, wr_beats);
        finish_test("imem_sets");
    endtask

    task automatic dual_port_miss();
        int icycles;
        int dcycles;
        fork
            read_check("dual_miss", 1'b1, 32'h0000_3004, icycles);
            read_check("dual_miss", 1'b0, 32'h0000_4028, dcycles);
        join
        finish_test("dual_miss");
    endtask

    task automatic random_mix();
        int         kind;
        int         cycles;
        word_t      offset;
        logic [3:0] mask;
        word_t      data;
        for (int n = 0; n < MIX_OPS; n++) begin
            kind   = $unsigned($random(seed)) % 3;
            offset = ($unsigned($random(seed)) % 64) * 32 + ($unsigned($random(seed)) % 8) * 4;
            mask   = $random(seed);
            data   = $random(seed);
            if (mask == 4'h0) mask = 4'hf;
            case (kind)
                0: read_check("random_mix", 1'b1, INSTR_BASE + offset, cycles);
                1: read_check("random_mix", 1'b0, DATA_BASE + offset, cycles);
                default: write_check("random_mix", DATA_BASE + offset, mask, data);
            endcase
        end
        finish_test("random_mix");
    endtask

    initial begin
        rst_i    = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_i = 1'b0;
        read_miss_then_hit();
        partial_write_merge();
        dirty_eviction();
        imem_set_sweep();
        dual_port_miss();
        random_mix();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_mem_hierarchy

`default_nettype wire

// File: tests/burst_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module burst_mem_model (
    input  logic                    clk,
    input  logic                    rst_i,
    input  mem_bus_pkg::burst_req_t bmem_req_i,
    output mem_bus_pkg::burst_t     bmem_rdata_o,
    output logic                    bmem_resp_o
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int MAX_LATENCY = 8;

    word_t  mem [word_t];  // sparse, untouched words read as ~addr
    integer seed = 63;
    int     latency;
    logic   is_write;
    word_t  base;

    function automatic word_t read_word(word_t addr);
        return mem.exists(addr) ? mem[addr] : ~addr;
    endfunction

    initial begin
        bmem_rdata_o = '0;
        bmem_resp_o  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst_i && (bmem_req_i.read || bmem_req_i.write)) begin
                is_write = bmem_req_i.write;
                base     = bmem_req_i.addr;
                latency  = 1 + ($unsigned($random(seed)) % MAX_LATENCY);
                repeat (latency) @(posedge clk);
                for (int beat = 0; beat < BURST_BEATS; beat++) begin
                    #2;
                    bmem_resp_o  = 1'b1;
                    bmem_rdata_o = is_write ? '0 :
                                   {read_word(base + 8 * beat + 4), read_word(base + 8 * beat)};
                    @(negedge clk);
                    if (is_write) begin  // wdata is stable mid cycle
                        mem[base + 8 * beat]     = bmem_req_i.wdata[31:0];
                        mem[base + 8 * beat + 4] = bmem_req_i.wdata[63:32];
                    end
                    @(posedge clk);
                end
                #2;
                bmem_resp_o  = 1'b0;
                bmem_rdata_o = '0;
            end
        end
    end

endmodule : burst_mem_model

`default_nettype wire

// File: design/mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module mem_hierarchy (
    input  logic                    clk,
    input  logic                    rst_i,
    input  mem_bus_pkg::word_req_t  imem_req_i,
    output mem_bus_pkg::word_rsp_t  imem_rsp_o,
    input  mem_bus_pkg::word_req_t  dmem_req_i,
    output mem_bus_pkg::word_rsp_t  dmem_rsp_o,
    output mem_bus_pkg::burst_req_t bmem_req_o,
    input  mem_bus_pkg::burst_t     bmem_rdata_i,
    input  logic                    bmem_resp_i
);
    import mem_bus_pkg::*;

    // cache to arbiter
    line_req_t icache_line_req;
    line_rsp_t icache_line_rsp;
    line_req_t dcache_line_req;
    line_rsp_t dcache_line_rsp;

    // arbiter to adaptor
    line_req_t mem_line_req;
    line_rsp_t mem_line_rsp;

    direct_mapped_cache #(
        .WRITABLE (1'b0)
    ) u_icache (
        .clk        (clk),
        .rst_i      (rst_i),
        .word_req_i (imem_req_i),
        .word_rsp_o (imem_rsp_o),
        .line_req_o (icache_line_req),
        .line_rsp_i (icache_line_rsp)
    );

    direct_mapped_cache #(
        .WRITABLE (1'b1)
    ) u_dcache (
        .clk        (clk),
        .rst_i      (rst_i),
        .word_req_i (dmem_req_i),
        .word_rsp_o (dmem_rsp_o),
        .line_req_o (dcache_line_req),
        .line_rsp_i (dcache_line_rsp)
    );

    cache_arbiter u_cache_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .icache_req_i (icache_line_req),
        .icache_rsp_o (icache_line_rsp),
        .dcache_req_i (dcache_line_req),
        .dcache_rsp_o (dcache_line_rsp),
        .mem_req_o    (mem_line_req),
        .mem_rsp_i    (mem_line_rsp)
    );

    cacheline_adaptor u_cacheline_adaptor (
        .clk          (clk),
        .rst_i        (rst_i),
        .line_req_i   (mem_line_req),
        .line_rsp_o   (mem_line_rsp),
        .bmem_req_o   (bmem_req_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule : mem_hierarchy

`default_nettype wire

// File: design/cacheline_adaptor.sv
`timescale 1ns/1ps
`default_nettype none

module cacheline_adaptor (
    input  logic                    clk,
    input  logic                    rst_i,
    input  mem_bus_pkg::line_req_t  line_req_i,
    output mem_bus_pkg::line_rsp_t  line_rsp_o,
    output mem_bus_pkg::burst_req_t bmem_req_o,
    input  mem_bus_pkg::burst_t     bmem_rdata_i,
    input  logic                    bmem_resp_i
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int BEAT_BITS  = $clog2(BURST_BEATS);
    localparam int BURST_BITS = $bits(burst_t);

    typedef enum logic [1:0] {
        A_IDLE,
        A_READ,
        A_WRITE,
        A_DONE   // resp cycle
    } state_e;

    state_e               state_q;
    logic [BEAT_BITS-1:0] beat_q;
    line_t                shift_q;
    word_t                addr_q;
    burst_t               shift_in;
    logic                 last_beat;

    assign last_beat = bmem_resp_i & (beat_q == BEAT_BITS'(BURST_BEATS - 1));
    assign shift_in  = (state_q == A_READ) ? bmem_rdata_i : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= A_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                A_IDLE: begin
                    beat_q <= '0;
                    if (line_req_i.write) begin
                        state_q <= A_WRITE;
                    end else if (line_req_i.read) begin
                        state_q <= A_READ;
                    end
                end
                A_READ, A_WRITE: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= A_DONE;
                    end
                end
                default: state_q <= A_IDLE;
            endcase
        end
    end

    // latched so the line side may move on after resp
    always_ff @(posedge clk) begin
        if (state_q == A_IDLE) begin
            addr_q  <= line_req_i.addr.raw;
            shift_q <= line_req_i.wdata;
        end else if ((state_q == A_READ || state_q == A_WRITE) && bmem_resp_i) begin
            shift_q <= {shift_in, shift_q[$bits(line_t)-1:BURST_BITS]};  // low beat first
        end
    end

    always_comb begin
        bmem_req_o.addr  = addr_q;
        bmem_req_o.read  = (state_q == A_READ);
        bmem_req_o.write = (state_q == A_WRITE);
        bmem_req_o.wdata = shift_q[BURST_BITS-1:0];

        line_rsp_o.rdata = shift_q;
        line_rsp_o.resp  = (state_q == A_DONE);
    end

endmodule : cacheline_adaptor

`default_nettype wire

// File: design/cache_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter (
    input  logic                   clk,
    input  logic                   rst_i,
    input  mem_bus_pkg::line_req_t icache_req_i,
    output mem_bus_pkg::line_rsp_t icache_rsp_o,
    input  mem_bus_pkg::line_req_t dcache_req_i,
    output mem_bus_pkg::line_rsp_t dcache_rsp_o,
    output mem_bus_pkg::line_req_t mem_req_o,
    input  mem_bus_pkg::line_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        G_NONE,
        G_ICACHE,
        G_DCACHE
    } grant_e;

    grant_e grant_q, grant_d;

    logic icache_want;
    logic dcache_want;

    assign icache_want = icache_req_i.read | icache_req_i.write;
    assign dcache_want = dcache_req_i.read | dcache_req_i.write;

    // new grant takes effect in the same cycle
    always_comb begin
        grant_d = grant_q;
        if (grant_q == G_NONE) begin
            if (dcache_want) begin
                grant_d = G_DCACHE;  // data side first
            end else if (icache_want) begin
                grant_d = G_ICACHE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            grant_q <= G_NONE;
        end else if (mem_rsp_i.resp) begin
            grant_q <= G_NONE;
        end else begin
            grant_q <= grant_d;
        end
    end

    always_comb begin
        case (grant_d)
            G_DCACHE: mem_req_o = dcache_req_i;
            G_ICACHE: mem_req_o = icache_req_i;
            default:  mem_req_o = '0;
        endcase

        // data fans out, resp only to the owner
        icache_rsp_o.rdata = mem_rsp_i.rdata;
        icache_rsp_o.resp  = mem_rsp_i.resp & (grant_q == G_ICACHE);
        dcache_rsp_o.rdata = mem_rsp_i.rdata;
        dcache_rsp_o.resp  = mem_rsp_i.resp & (grant_q == G_DCACHE);
    end

endmodule : cache_arbiter

`default_nettype wire

// File: design/direct_mapped_cache.sv
`timescale 1ns/1ps
`default_nettype none

module direct_mapped_cache #(
    parameter bit WRITABLE = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  mem_bus_pkg::word_req_t word_req_i,
    output mem_bus_pkg::word_rsp_t word_rsp_o,
    output mem_bus_pkg::line_req_t line_req_o,
    input  mem_bus_pkg::line_rsp_t line_rsp_i
);
    import cache_types_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPARE,   // replay after a fill
        S_WRITEBACK,
        S_FILL
    } state_e;

    state_e state_q, state_d;

    // arrays
    logic [NUM_SETS-1:0] valid_q;
    logic [TAG_BITS-1:0] tag_q [NUM_SETS];
    line_t               data_q [NUM_SETS];

    logic  resp_q;
    word_t rdata_q;

    cache_addr_u         req_addr;
    cache_addr_u         fill_addr;
    cache_addr_u         wb_addr;
    logic [SET_BITS-1:0] set_idx;
    line_t               rd_line;
    line_t               merged_line;
    word_t               rd_word;

    logic lookup;
    logic hit;
    logic hit_fire;
    logic write_fire;
    logic fill_done;
    logic victim_dirty;

    assign req_addr.raw = word_req_i.addr;
    assign set_idx      = req_addr.f.set;
    assign rd_line      = data_q[set_idx];
    assign rd_word      = rd_line[{req_addr.f.word_idx, 5'b0} +: 32];

    // a held request is not looked up again while its resp is out
    assign lookup = (word_req_i.read | word_req_i.write) & ~resp_q &
                    ((state_q == S_IDLE) | (state_q == S_COMPARE));
    assign hit       = valid_q[set_idx] & (tag_q[set_idx] == req_addr.f.tag);
    assign hit_fire  = lookup & hit;
    assign fill_done = (state_q == S_FILL) & line_rsp_i.resp;

    if (WRITABLE) begin : g_write_path
        logic [NUM_SETS-1:0] dirty_q;
        line_mask_t          byte_en;
        line_t               wr_line;

        // wmask moved to the word's slot in the line
        assign byte_en = line_mask_t'(word_req_i.wmask) << {req_addr.f.word_idx, 2'b00};
        assign wr_line = {WORDS_PER_LINE{word_req_i.wdata}};

        assign write_fire   = hit_fire & word_req_i.write;
        assign victim_dirty = valid_q[set_idx] & dirty_q[set_idx];

        always_comb begin
            merged_line = rd_line;
            for (int b = 0; b < $bits(line_mask_t); b++) begin
                if (byte_en[b]) begin
                    merged_line[b*8 +: 8] = wr_line[b*8 +: 8];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (rst_i) begin
                dirty_q <= '0;
            end else if (fill_done) begin
                dirty_q[set_idx] <= 1'b0;  // fresh from memory
            end else if (write_fire) begin
                dirty_q[set_idx] <= 1'b1;
            end
        end
    end else begin : g_read_only
        assign write_fire   = 1'b0;
        assign victim_dirty = 1'b0;
        assign merged_line  = rd_line;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_COMPARE: begin
                if (lookup) begin
                    if (hit) begin
                        state_d = S_IDLE;
                    end else if (victim_dirty) begin
                        state_d = S_WRITEBACK;
                    end else begin
                        state_d = S_FILL;
                    end
                end
            end
            S_WRITEBACK: begin
                if (line_rsp_i.resp) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (line_rsp_i.resp) begin
                    state_d = S_COMPARE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            resp_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            resp_q  <= hit_fire;  // one cycle pulse
            if (fill_done) begin
                valid_q[set_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit_fire) begin
            rdata_q <= rd_word;
        end
        if (fill_done) begin
            tag_q[set_idx]  <= req_addr.f.tag;
            data_q[set_idx] <= line_rsp_i.rdata;
        end else if (write_fire) begin
            data_q[set_idx] <= merged_line;
        end
    end

    // line addresses for fill and victim
    always_comb begin
        fill_addr            = req_addr;
        fill_addr.f.word_idx = '0;
        fill_addr.f.byte_idx = '0;
        wb_addr              = fill_addr;
        wb_addr.f.tag        = tag_q[set_idx];
    end

    always_comb begin
        line_req_o.addr  = (state_q == S_WRITEBACK) ? wb_addr : fill_addr;
        line_req_o.read  = (state_q == S_FILL);
        line_req_o.write = (state_q == S_WRITEBACK);
        line_req_o.wdata = rd_line;  // victim line

        word_rsp_o.rdata = rdata_q;
        word_rsp_o.resp  = resp_q;
    end

endmodule : direct_mapped_cache

`default_nettype wire

// File: design/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    localparam int BURST_BEATS = 4;  // 64-bit beats per line

    typedef logic [63:0] burst_t;

    // cpu side word port
    typedef struct packed {
        cache_types_pkg::word_t addr;
        logic                   read;
        logic                   write;
        logic [3:0]             wmask;
        cache_types_pkg::word_t wdata;
    } word_req_t;

    typedef struct packed {
        cache_types_pkg::word_t rdata;
        logic                   resp;
    } word_rsp_t;

    // line port, addr always line aligned
    typedef struct packed {
        cache_types_pkg::cache_addr_u addr;
        logic                         read;
        logic                         write;
        cache_types_pkg::line_t       wdata;
    } line_req_t;

    typedef struct packed {
        cache_types_pkg::line_t rdata;
        logic                   resp;
    } line_rsp_t;

    // external burst memory
    typedef struct packed {
        cache_types_pkg::word_t addr;
        logic                   read;
        logic                   write;
        burst_t                 wdata;
    } burst_req_t;

endpackage : mem_bus_pkg

`default_nettype wire

// File: design/cache_types_pkg.sv
`default_nettype none

package cache_types_pkg;

    localparam int SET_BITS       = 3;
    localparam int OFFSET_BITS    = 5;
    localparam int TAG_BITS       = 32 - SET_BITS - OFFSET_BITS;
    localparam int NUM_SETS       = 1 << SET_BITS;
    localparam int WORDS_PER_LINE = 8;

    typedef logic [31:0]  word_t;
    typedef logic [255:0] line_t;
    typedef logic [31:0]  line_mask_t;  // one enable per line byte

    // tag | set | word | byte
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [SET_BITS-1:0]    set;
        logic [OFFSET_BITS-3:0] word_idx;
        logic [1:0]             byte_idx;
    } cache_addr_fields_t;

    typedef union packed {
        word_t              raw;
        cache_addr_fields_t f;
    } cache_addr_u;

endpackage : cache_types_pkg

`default_nettype wire
